// ==== bench/tb_string_led.sv ====
`timescale 1ns/1ps

module tb_string_led import led_pkg::*; ();

  localparam int BUS_TIMEOUT   = 16;
  localparam int IRQ_TIMEOUT   = 64;
  localparam int FRAME_TIMEOUT = 200000;

  logic             clk;
  logic             rst_n;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [BUS_W-1:0] wb_adr;
  logic [BUS_W-1:0] wb_dat_w;
  logic [BUS_W-1:0] wb_dat_r;
  logic             wb_ack;
  logic             irq;
  logic             sout;

  integer     seed = 28367;
  logic [7:0] model_mem [256]; // Mirror of the frame buffer
  logic       exp_bits [$];
  logic       got_bits [$];
  logic       dec_on = 1'b0;
  logic       dec_pol;
  int         dec_presc;
  int         run_len = 0;
  int         irq_cnt = 0;
  int         irq_base;

  string_led_top u_string_led_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack),
    .irq_o    (irq),
    .sout_o   (sout)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Line decoder turns each active run into one bit
  always @(negedge clk) begin
    if (!dec_on) begin
      run_len <= 0;
    end else if (sout == dec_pol) begin
      run_len <= run_len + 1;
    end else if (run_len != 0) begin
      got_bits.push_back(run_len > 12 * (dec_presc + 1)); // Long run is a 1
      run_len <= 0;
    end
  end

  always @(negedge clk) begin
    if (irq) irq_cnt <= irq_cnt + 1;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [BUS_W-1:0] got,
                            input logic [BUS_W-1:0] exp);
    if (got !== exp) fail_now($sformatf("Fail %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(input int n, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("Fail sout_o decoded bit %0d got %h expected %h", n, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("Fail %s got %h expected %h", name, got, exp));
  endtask

  //////////////////////////////
  // Bus and register helpers
  //////////////////////////////

  function automatic logic [BUS_W-1:0] reg_addr(input reg_sel_e sel);
    return BUS_W'({sel, 2'b00});
  endfunction

  function automatic logic [BUS_W-1:0] buf_addr(input logic [LED_IDX_W-1:0] idx);
    return (BUS_W'(1) << BUF_SEL_BIT) | BUS_W'({idx, 2'b00});
  endfunction

  function automatic logic [BUS_W-1:0] cfg_word(input logic en, input logic ien, input logic pol);
    return {en, ien, pol, 29'd0};
  endfunction

  function automatic logic [BUS_W-1:0] ctrl_word(input logic [REPEAT_W-1:0] rep,
      input logic [LED_IDX_W-1:0] last, input logic [LED_IDX_W-1:0] first);
    logic [BUS_W-1:0] w;
    w = '0;
    w[31] = 1'b1; // Start
    w[25 +: REPEAT_W] = rep;
    w[12 +: LED_IDX_W] = last;
    w[0 +: LED_IDX_W] = first;
    return w;
  endfunction

  task automatic bus_cycle(input logic we, input logic [BUS_W-1:0] adr,
                           input logic [BUS_W-1:0] dat, output logic [BUS_W-1:0] rdata);
    int n;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    n = 0;
    @(negedge clk);
    while (!wb_ack) begin
      if (n == BUS_TIMEOUT) fail_now("Bus request was never acknowledged");
      n++;
      @(negedge clk);
    end
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic bus_write(input logic [BUS_W-1:0] adr, input logic [BUS_W-1:0] dat);
    logic [BUS_W-1:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic bus_read(input logic [BUS_W-1:0] adr, output logic [BUS_W-1:0] rdata);
    bus_cycle(1'b0, adr, '0, rdata);
  endtask

  task automatic setup(input logic ien, input logic pol, input int presc);
    bus_write(reg_addr(REG_PRESC), BUS_W'(presc));
    bus_write(reg_addr(REG_CONFIG), cfg_word(1'b1, ien, pol));
    repeat (4) @(posedge clk); // Line settles to the idle level
  endtask

  task automatic fill_range(input logic [LED_IDX_W-1:0] first, input int len);
    logic [LED_IDX_W-1:0] idx;
    logic [31:0]          tmp;
    for (int i = 0; i < len; i++) begin
      idx = first + LED_IDX_W'(i);
      tmp = $random(seed);
      model_mem[idx] = tmp[7:0];
      bus_write(buf_addr(idx), tmp);
    end
  endtask

  //////////////////////////////
  // Frame run and compare
  //////////////////////////////

  task automatic start_frame(input logic [LED_IDX_W-1:0] first, input logic [LED_IDX_W-1:0] last,
                             input logic [REPEAT_W-1:0] rep, input logic pol, input int presc);
    logic [LED_IDX_W-1:0] idx;
    logic [BUS_W-1:0]     rd;
    exp_bits.delete();
    for (int p = 0; p <= int'(rep); p++) begin
      idx = first;
      for (int b = 7; b >= 0; b--) exp_bits.push_back(model_mem[idx][b]);
      while (idx != last) begin
        idx++;
        for (int b = 7; b >= 0; b--) exp_bits.push_back(model_mem[idx][b]);
      end
    end
    got_bits.delete();
    dec_pol   = pol;
    dec_presc = presc;
    dec_on    = 1'b1;
    irq_base  = irq_cnt;
    bus_write(reg_addr(REG_CTRL), ctrl_word(rep, last, first));
    bus_read(reg_addr(REG_CTRL), rd);
    check_flag("busy during frame", rd[29], 1'b1);
  endtask

  task automatic finish_frame(input int presc, input logic ien);
    logic [BUS_W-1:0] rd;
    int               n;
    n = 0;
    bus_read(reg_addr(REG_CTRL), rd);
    while (rd[29]) begin
      if (n == FRAME_TIMEOUT / 4) fail_now("Busy never fell at the end of the frame");
      n++;
      bus_read(reg_addr(REG_CTRL), rd);
    end
    n = 0;
    while (ien && irq_cnt == irq_base) begin
      if (n == IRQ_TIMEOUT) fail_now("No interrupt after the frame ended");
      n++;
      @(posedge clk);
    end
    n = 0;
    while (got_bits.size() < exp_bits.size()) begin
      if (n == FRAME_TIMEOUT) fail_now("Serial line stopped before the whole frame was seen");
      n++;
      @(posedge clk);
    end
    repeat (30 * (presc + 1)) @(posedge clk); // Longer than one symbol
    dec_on = 1'b0;
    if (got_bits.size() != exp_bits.size()) fail_now("Extra pulses on the serial line");
    for (int i = 0; i < exp_bits.size(); i++) check_bit(i, got_bits[i], exp_bits[i]);
    check_flag("irq_o pulsed", irq_cnt != irq_base, ien);
    check_flag("irq_o repeated", irq_cnt - irq_base > 1, 1'b0);
  endtask

  initial begin
    logic [BUS_W-1:0]     r;
    logic [BUS_W-1:0]     rd;
    logic [LED_IDX_W-1:0] first;
    logic [LED_IDX_W-1:0] last;
    logic [REPEAT_W-1:0]  rep;
    int                   presc;
    int                   len;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    rst_n    <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("wb_ack_o after reset", wb_ack, 1'b0);
    check_flag("irq_o after reset", irq, 1'b0);
    check_flag("sout_o after reset", sout, 1'b0);

    // Register readback with fields masked
    for (int k = 0; k < 4; k++) begin
      r = $random(seed);
      bus_write(reg_addr(REG_CONFIG), r);
      bus_read(reg_addr(REG_CONFIG), rd);
      check_word("REG_CONFIG", rd, r & 32'hE000_0000);
      r = $random(seed);
      bus_write(reg_addr(REG_PRESC), r);
      bus_read(reg_addr(REG_PRESC), rd);
      check_word("REG_PRESC", rd, r & 32'h0000_FFFF);
      r = $random(seed) & 32'h7FFF_FFFF; // No start
      bus_write(reg_addr(REG_CTRL), r);
      bus_read(reg_addr(REG_CTRL), rd);
      check_word("REG_CTRL", rd, r & 32'h1E0F_F0FF);
      bus_write(reg_addr(REG_UNUSED), $random(seed));
      bus_read(reg_addr(REG_UNUSED), rd);
      check_word("REG_UNUSED", rd, '0);
      r = $random(seed);
      bus_read(buf_addr(r[LED_IDX_W-1:0]), rd);
      check_word("buffer read", rd, '0);
    end

    // Single pass with irq enabled then disabled
    for (int t = 0; t < 2; t++) begin
      setup(t == 0, 1'b1, 1);
      r     = $random(seed);
      first = r[LED_IDX_W-1:0];
      len   = 1 + int'(r[17:16]);
      last  = first + LED_IDX_W'(len - 1);
      fill_range(first, len);
      start_frame(first, last, '0, 1'b1, 1);
      finish_frame(1, t == 0);
    end

    // Repeats with active low pulses
    r     = $random(seed);
    presc = int'(r[25:24]) % 3;
    rep   = REPEAT_W'(1 + int'(r[21:20]));
    first = r[LED_IDX_W-1:0];
    last  = first + LED_IDX_W'(r[17:16]);
    setup(1'b1, 1'b0, presc);
    fill_range(first, int'(r[17:16]) + 1);
    start_frame(first, last, rep, 1'b0, presc);
    finish_frame(presc, 1'b1);

    // Abort by clearing enable and then a clean rerun
    r     = $random(seed);
    first = r[LED_IDX_W-1:0];
    last  = first + LED_IDX_W'(4);
    setup(1'b1, 1'b1, 1);
    fill_range(first, 5);
    start_frame(first, last, '0, 1'b1, 1);
    len = 0;
    while (got_bits.size() < 3) begin
      if (len == FRAME_TIMEOUT) fail_now("No bits seen before the abort");
      len++;
      @(posedge clk);
    end
    dec_on = 1'b0;
    bus_write(reg_addr(REG_CONFIG), cfg_word(1'b0, 1'b1, 1'b1)); // irq_en stays set
    bus_read(reg_addr(REG_CTRL), rd);
    check_flag("busy after abort", rd[29], 1'b0);
    for (int k = 0; k < 60; k++) begin
      @(negedge clk);
      check_flag("sout_o while disabled", sout, 1'b0);
    end
    check_flag("irq_o after abort", irq_cnt != irq_base, 1'b0);
    setup(1'b0, 1'b1, 1);
    start_frame(first, last, '0, 1'b1, 1);
    finish_frame(1, 1'b0);

    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== project.f ====
rtl/led_pkg.sv
rtl/led_cfg_if.sv
rtl/led_regs.sv
rtl/frame_buffer.sv
rtl/frame_sequencer.sv
rtl/bit_encoder.sv
rtl/string_led_top.sv
bench/tb_string_led.sv

// ==== rtl/bit_encoder.sv ====
`timescale 1ns/1ps

module bit_encoder import led_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               enable_i,
  input  logic               polarity_i,
  input  logic [PRESC_W-1:0] presc_i,
  input  logic               bit_val_i,
  input  logic               bit_valid_i,
  output logic               bit_ready_o,
  output logic               sout_o
);

  logic [PRESC_W-1:0]    presc_cnt;
  logic [TICK_CNT_W-1:0] tick_cnt; // Symbol position, TICKS_PER_BIT when idle
  logic                  tick;
  logic                  idle;
  logic                  at_bound;
  logic                  take;
  logic                  dbit;
  logic                  polar;
  logic [TICK_CNT_W-1:0] active_len;
  logic                  level;

  // One tick every presc_i + 1 clocks
  assign tick     = (presc_cnt >= presc_i);
  assign idle     = (tick_cnt == TICK_CNT_W'(TICKS_PER_BIT));
  assign at_bound = (tick_cnt >= TICK_CNT_W'(TICKS_PER_BIT - 1)); // Last tick or idle
  assign take     = enable_i && tick && at_bound && bit_valid_i;

  assign bit_ready_o = take;

  // Pulse width coding, active part first
  assign active_len = dbit ? TICK_CNT_W'(T1_ACTIVE) : TICK_CNT_W'(T0_ACTIVE);
  assign level      = idle ? !polarity_i : ((tick_cnt < active_len) ? polar : !polar);

  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      presc_cnt <= '0;
      tick_cnt  <= TICK_CNT_W'(TICKS_PER_BIT);
      sout_o    <= 1'b0; // Line parked low
    end else begin
      presc_cnt <= tick ? '0 : presc_cnt + 1'b1;
      if (take) begin
        tick_cnt <= '0;
      end else if (tick && at_bound) begin
        tick_cnt <= TICK_CNT_W'(TICKS_PER_BIT); // Nothing offered, wait
      end else if (tick) begin
        tick_cnt <= tick_cnt + 1'b1;
      end
      sout_o <= level;
    end
  end

  // Bit and polarity fixed for the whole symbol
  always_ff @(posedge clk) begin
    if (take) begin
      dbit  <= bit_val_i;
      polar <= polarity_i;
    end
  end

endmodule

// ==== rtl/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer import led_pkg::*; (
  input  logic                 clk,
  input  logic                 we_i,
  input  logic [LED_IDX_W-1:0] waddr_i,
  input  logic [7:0]           wdata_i,
  input  logic                 rd_en_i,
  input  logic [LED_IDX_W-1:0] rd_addr_i,
  output logic [7:0]           rd_data_o
);

  logic [7:0] mem [1 << LED_IDX_W];

  // Host side
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Sequencer side, data one cycle after the request
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

// ==== rtl/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer import led_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  led_cfg_if.seq               cfg,
  output logic                 rd_en_o,
  output logic [LED_IDX_W-1:0] rd_addr_o,
  input  logic [7:0]           rd_data_i,
  output logic                 bit_val_o,
  output logic                 bit_valid_o,
  input  logic                 bit_ready_i
);

  seq_state_e           state;
  logic [LED_IDX_W-1:0] idx;      // Byte being sent
  logic [LED_IDX_W-1:0] first_q;
  logic [LED_IDX_W-1:0] last_q;
  logic [REPEAT_W-1:0]  rep_left; // Passes still to go after this one
  logic [2:0]           bit_cnt;  // 7 down to 0, MSB first
  logic [7:0]           byte_q;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      idx      <= '0;
      first_q  <= '0;
      last_q   <= '0;
      rep_left <= '0;
      bit_cnt  <= '0;
    end else if (!cfg.enable) begin
      state <= S_IDLE; // Abort any frame in flight
    end else begin
      case (state)
        S_IDLE: begin
          if (cfg.start) begin
            first_q  <= cfg.first_idx;
            last_q   <= cfg.last_idx;
            rep_left <= cfg.repeat_cnt;
            idx      <= cfg.first_idx;
            state    <= S_FETCH;
          end
        end
        S_FETCH: state <= S_LOAD;
        S_LOAD: begin
          bit_cnt <= 3'd7;
          state   <= S_SEND;
        end
        S_SEND: begin
          if (bit_ready_i) begin
            if (bit_cnt != 3'd0) begin
              bit_cnt <= bit_cnt - 3'd1;
            end else if (idx != last_q) begin
              idx   <= idx + 1'b1;
              state <= S_FETCH;
            end else if (rep_left != '0) begin
              // Wrap for another pass
              rep_left <= rep_left - 1'b1;
              idx      <= first_q;
              state    <= S_FETCH;
            end else begin
              state <= S_IDLE;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_LOAD) begin
      byte_q <= rd_data_i;
    end
  end

  assign rd_en_o     = (state == S_FETCH);
  assign rd_addr_o   = idx;
  assign bit_valid_o = (state == S_SEND); // Held until the encoder takes it
  assign bit_val_o   = byte_q[bit_cnt];
  assign cfg.busy    = (state != S_IDLE);

endmodule

// ==== rtl/led_cfg_if.sv ====
`timescale 1ns/1ps

interface led_cfg_if import led_pkg::*; ();

  logic                 enable;
  logic                 polarity;
  logic [LED_IDX_W-1:0] first_idx;
  logic [LED_IDX_W-1:0] last_idx;
  logic [REPEAT_W-1:0]  repeat_cnt; // Extra passes over the range
  logic                 start;      // One cycle pulse
  logic                 busy;

  modport regs (
    output enable, polarity, first_idx, last_idx, repeat_cnt, start,
    input  busy
  );

  modport seq (
    input  enable, first_idx, last_idx, repeat_cnt, start,
    output busy
  );

endinterface

// ==== rtl/led_pkg.sv ====
package led_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int BUS_W     = 32; // Bus data and address
  localparam int LED_IDX_W = 8;  // 256 byte frame buffer
  localparam int REPEAT_W  = 4;
  localparam int PRESC_W   = 16;

  //////////////////////////////
  // Symbol timing, in ticks
  //////////////////////////////

  localparam int TICKS_PER_BIT = 24;
  localparam int T0_ACTIVE     = 8;  // Short pulse for a 0
  localparam int T1_ACTIVE     = 16; // Long pulse for a 1

  // Also holds TICKS_PER_BIT, the idle marker in the encoder
  localparam int TICK_CNT_W = $clog2(TICKS_PER_BIT + 1);

  localparam int BUF_SEL_BIT = 12; // High half of the map is the buffer

  // Register select, address bits 3:2
  typedef enum logic [1:0] {
    REG_CONFIG = 2'b00, // enable 31, irq_en 30, polarity 29
    REG_PRESC  = 2'b01, // prescale 15:0
    REG_UNUSED = 2'b10,
    REG_CTRL   = 2'b11  // start 31, busy 29, repeat 28:25, last 19:12, first 7:0
  } reg_sel_e;

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH, // Read request to the buffer
    S_LOAD,  // Byte arrives
    S_SEND
  } seq_state_e;

endpackage

// ==== rtl/led_regs.sv ====
`timescale 1ns/1ps

module led_regs import led_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [BUS_W-1:0]     wb_adr_i,
  input  logic [BUS_W-1:0]     wb_dat_i,
  output logic [BUS_W-1:0]     wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 irq_o,
  led_cfg_if.regs              cfg,
  output logic [PRESC_W-1:0]   presc_o,
  output logic                 buf_we_o,
  output logic [LED_IDX_W-1:0] buf_waddr_o,
  output logic [7:0]           buf_wdata_o
);

  logic             req;
  logic             buf_hit;
  reg_sel_e         sel;
  logic             irq_en;
  logic             start_pend; // Start seen, fires after the ack
  logic             busy_q;
  logic [BUS_W-1:0] rd_word;

  assign req     = wb_cyc_i && wb_stb_i && !wb_ack_o; // Not yet acked
  assign buf_hit = wb_adr_i[BUF_SEL_BIT];
  assign sel     = reg_sel_e'(wb_adr_i[3:2]);

  // Readback, buffer window and spare slot read zero
  always_comb begin
    rd_word = '0;
    if (!buf_hit) begin
      case (sel)
        REG_CONFIG: begin
          rd_word[31] = cfg.enable;
          rd_word[30] = irq_en;
          rd_word[29] = cfg.polarity;
        end
        REG_PRESC: rd_word[0 +: PRESC_W] = presc_o;
        REG_CTRL: begin
          rd_word[29]             = cfg.busy;
          rd_word[25 +: REPEAT_W] = cfg.repeat_cnt;
          rd_word[12 +: LED_IDX_W] = cfg.last_idx;
          rd_word[0 +: LED_IDX_W]  = cfg.first_idx;
        end
        default: rd_word = '0;
      endcase
    end
  end

  //////////////////////////////
  // Bus cycle and config fields
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack_o       <= 1'b0;
      buf_we_o       <= 1'b0;
      start_pend     <= 1'b0;
      cfg.start      <= 1'b0;
      cfg.enable     <= 1'b0;
      cfg.polarity   <= 1'b0;
      cfg.first_idx  <= '0;
      cfg.last_idx   <= '0;
      cfg.repeat_cnt <= '0;
      irq_en         <= 1'b0;
      presc_o        <= '0;
    end else begin
      wb_ack_o   <= req;
      buf_we_o   <= req && wb_we_i && buf_hit; // High during the ack
      start_pend <= req && wb_we_i && !buf_hit && (sel == REG_CTRL) && wb_dat_i[31];
      cfg.start  <= start_pend;

      if (req && wb_we_i && !buf_hit) begin
        case (sel)
          REG_CONFIG: begin
            cfg.enable   <= wb_dat_i[31];
            irq_en       <= wb_dat_i[30];
            cfg.polarity <= wb_dat_i[29];
          end
          REG_PRESC: presc_o <= wb_dat_i[0 +: PRESC_W];
          REG_CTRL: begin
            cfg.repeat_cnt <= wb_dat_i[25 +: REPEAT_W];
            cfg.last_idx   <= wb_dat_i[12 +: LED_IDX_W];
            cfg.first_idx  <= wb_dat_i[0 +: LED_IDX_W];
          end
          default: ;
        endcase
      end
    end
  end

  // Read data and buffer write payload
  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_o <= rd_word;
    end
    buf_waddr_o <= wb_adr_i[2 +: LED_IDX_W]; // Word addressed
    buf_wdata_o <= wb_dat_i[7:0];
  end

  // Frame done interrupt, skipped when the frame was aborted
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      irq_o  <= 1'b0;
    end else begin
      busy_q <= cfg.busy;
      irq_o  <= irq_en && cfg.enable && busy_q && !cfg.busy;
    end
  end

endmodule

// ==== rtl/string_led_top.sv ====
`timescale 1ns/1ps

module string_led_top import led_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  input  logic             wb_we_i,
  input  logic [BUS_W-1:0] wb_adr_i,
  input  logic [BUS_W-1:0] wb_dat_i,
  output logic [BUS_W-1:0] wb_dat_o,
  output logic             wb_ack_o,
  output logic             irq_o,
  output logic             sout_o
);

  logic [PRESC_W-1:0]   presc;
  logic                 buf_we;
  logic [LED_IDX_W-1:0] buf_waddr;
  logic [7:0]           buf_wdata;
  logic                 rd_en;
  logic [LED_IDX_W-1:0] rd_addr;
  logic [7:0]           rd_data;
  logic                 bit_val;
  logic                 bit_valid;
  logic                 bit_ready;

  led_cfg_if cfg_if ();

  led_regs u_led_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .irq_o       (irq_o),
    .cfg         (cfg_if.regs),
    .presc_o     (presc),
    .buf_we_o    (buf_we),
    .buf_waddr_o (buf_waddr),
    .buf_wdata_o (buf_wdata)
  );

  frame_buffer u_frame_buffer (
    .clk       (clk),
    .we_i      (buf_we),
    .waddr_i   (buf_waddr),
    .wdata_i   (buf_wdata),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  frame_sequencer u_frame_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg         (cfg_if.seq),
    .rd_en_o     (rd_en),
    .rd_addr_o   (rd_addr),
    .rd_data_i   (rd_data),
    .bit_val_o   (bit_val),
    .bit_valid_o (bit_valid),
    .bit_ready_i (bit_ready)
  );

  bit_encoder u_bit_encoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable_i    (cfg_if.enable),
    .polarity_i  (cfg_if.polarity),
    .presc_i     (presc),
    .bit_val_i   (bit_val),
    .bit_valid_i (bit_valid),
    .bit_ready_o (bit_ready),
    .sout_o      (sout_o)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the LED string controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_string_led -f project.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
